//--- verilog/soc_macros.svh
//--------------------
// System bus core constants
// Reset timing, GPIO widths, CSR numbers and bus bounds
//--------------------
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Reset sequencing, in sys_clk edges after the trigger falls
`define SOC_RST_HOLD 16
`define SOC_FLASH_RST 8

// System controller GPIO widths
`define SOC_GPIO_IN_W 7
`define SOC_GPIO_OUT_W 2

// CSR peripheral number of the system controller
`define SOC_SYSCTL_CSR 1

// Lowest address bit of the locked range check
`define SOC_LOCKED_MSB 18

// Worst case strobe to ack, in cycles
`define SOC_ACK_BOUND 6

`endif

//--- verilog/soc_pkg.sv
//--------------------
// Shared bus and CSR types
// Wishbone words, CSR address fields, register and region codes
//--------------------
`default_nettype none

package soc_pkg;

	// Wishbone side
	typedef logic [31:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;

	// CSR address is bus address bits 16..2
	typedef logic [14:0] csr_addr_t;

	// Top five CSR address bits select the peripheral
	typedef logic [4:0] csr_periph_t;

	// System controller register index, low ten CSR address bits
	typedef enum logic [9:0] {
		GPIO_IN   = 10'd0,
		GPIO_OUT  = 10'd1,
		CONTROL   = 10'd2,
		TIMER_CMP = 10'd3,
		TIMER_CNT = 10'd4,
		IRQ_STAT  = 10'd5
	} sysctl_reg_e;

	// Address class, bit 31 already dropped
	typedef enum logic [1:0] {
		REGION_CSR,
		REGION_LOCKED,
		REGION_OTHER
	} region_e;

endpackage

`default_nettype wire

//--- verilog/soc_ifs.sv
//--------------------
// Internal bus interfaces
// Decoded request from the bus side, CSR cycle to peripherals
//--------------------
`default_nettype none

// Accepted Wishbone access, held until the next valid pulse
interface bus_req_if;
	logic                req_valid;
	logic                req_we;
	soc_pkg::region_e    req_region;
	soc_pkg::csr_addr_t  req_csr_a;
	soc_pkg::wb_data_t   req_dat;

	modport decoder (
		output req_valid,
		output req_we,
		output req_region,
		output req_csr_a,
		output req_dat
	);

	modport bridge (
		input req_valid,
		input req_we,
		input req_region,
		input req_csr_a,
		input req_dat
	);

	// Result side only needs the access kind
	modport result (
		input req_we,
		input req_region
	);
endinterface

// Shared CSR bus, read data registered in the peripheral
interface csr_bus_if;
	soc_pkg::csr_addr_t  csr_a;
	logic                csr_we;
	soc_pkg::wb_data_t   csr_dw;
	soc_pkg::wb_data_t   csr_dr;

	modport master (output csr_a, output csr_we, output csr_dw, input csr_dr);
	modport slave (input csr_a, input csr_we, input csr_dw, output csr_dr);
endinterface

`default_nettype wire

//--- verilog/reset_gen.sv
//--------------------
// Reset generator
// Stretches the system reset after the trigger
// and lets the flash out of reset first
//--------------------
`default_nettype none
`include "soc_macros.svh"

module reset_gen (
	input  logic sys_clk,
	input  logic trigger_reset,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);
	// Wide enough to hold the longer of the two delays
	localparam int CNT_W = $clog2(`SOC_RST_HOLD + 1);

	logic [CNT_W-1:0] rel_cnt;

	// Edge count since the trigger fell, stops at the hold time
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			rel_cnt <= '0;
		end else if (rel_cnt != CNT_W'(`SOC_RST_HOLD)) begin
			rel_cnt <= rel_cnt + 1'b1;
		end
	end

	// Flash released on edge SOC_FLASH_RST, system on edge SOC_RST_HOLD
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			sys_rst_o     <= 1'b1;
			flash_rst_n_o <= 1'b0;
		end else begin
			if (rel_cnt == CNT_W'(`SOC_FLASH_RST - 1))
				flash_rst_n_o <= 1'b1;
			if (rel_cnt == CNT_W'(`SOC_RST_HOLD - 1))
				sys_rst_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/bus_decode.sv
//--------------------
// Bus request decoder
// Accepts one Wishbone access at a time and classifies its region
//--------------------
`default_nettype none
`include "soc_macros.svh"

module bus_decode (
	input  logic              sys_clk,
	input  logic              sys_rst,
	input  soc_pkg::wb_addr_t wb_adr_i,
	input  soc_pkg::wb_data_t wb_dat_i,
	input  logic              wb_we_i,
	input  logic              wb_cyc_i,
	input  logic              wb_stb_i,
	input  logic              resp,
	bus_req_if.decoder        req
);
	logic             busy;
	logic             start;
	logic [30:0]      adr_low;
	soc_pkg::region_e region;

	// MSB ignored, shadow region aliases the base
	assign adr_low = wb_adr_i[30:0];
	assign start   = ~busy & wb_cyc_i & wb_stb_i;

	// Region classification
	always_comb begin
		if (adr_low[30] & adr_low[29])
			region = soc_pkg::REGION_CSR;
		else if (adr_low[30:`SOC_LOCKED_MSB] == '0)
			region = soc_pkg::REGION_LOCKED;
		else
			region = soc_pkg::REGION_OTHER;
	end

	// Busy from accept until ack or err comes back
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			busy          <= 1'b0;
			req.req_valid <= 1'b0;
		end else begin
			req.req_valid <= start;
			if (start)
				busy <= 1'b1;
			else if (resp)
				busy <= 1'b0;
		end
	end

	// Request payload, stable until the next accept
	always_ff @(posedge sys_clk) begin
		if (start) begin
			req.req_we     <= wb_we_i;
			req.req_region <= region;
			req.req_csr_a  <= adr_low[16:2];
			req.req_dat    <= wb_dat_i;
		end
	end

endmodule

`default_nettype wire

//--- verilog/csr_bridge.sv
//--------------------
// Wishbone to CSR bridge
// Turns a mapped request into one CSR write or read cycle
//--------------------
`default_nettype none

module csr_bridge (
	input  logic              sys_clk,
	input  logic              sys_rst,
	bus_req_if.bridge         req,
	csr_bus_if.master         csr,
	output logic              done,
	output soc_pkg::wb_data_t rd_data
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_RD_ADDR,
		ST_RD_DATA
	} state_e;

	state_e state;
	logic   csr_hit;

	assign csr_hit = req.req_region == soc_pkg::REGION_CSR;

	//--------------------
	// Control
	//--------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state      <= ST_IDLE;
			csr.csr_we <= 1'b0;
			done       <= 1'b0;
		end else begin
			// Pulses by default
			csr.csr_we <= 1'b0;
			done       <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req.req_valid) begin
						if (!csr_hit) begin
							// Unmapped, nothing to run on the CSR side
							done <= 1'b1;
						end else if (req.req_we) begin
							csr.csr_we <= 1'b1;
							state      <= ST_WRITE;
						end else begin
							state <= ST_RD_ADDR;
						end
					end
				end
				// Write strobe out this cycle
				ST_WRITE: begin
					done  <= 1'b1;
					state <= ST_IDLE;
				end
				// Peripheral registers its read data
				ST_RD_ADDR: state <= ST_RD_DATA;
				ST_RD_DATA: begin
					done  <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//--------------------
	// Datapath
	//--------------------
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE && req.req_valid && csr_hit) begin
			csr.csr_a  <= req.req_csr_a;
			csr.csr_dw <= req.req_dat;
		end
		if (state == ST_RD_DATA)
			rd_data <= csr.csr_dr;
	end

endmodule

`default_nettype wire

//--- verilog/sysctl_regs.sv
//--------------------
// System controller
// GPIO in and out, bus error enable,
// one auto-reloading timer with its interrupt
//--------------------
`default_nettype none
`include "soc_macros.svh"

module sysctl_regs (
	input  logic                       sys_clk,
	input  logic                       sys_rst,
	csr_bus_if.slave                   csr,
	input  logic [`SOC_GPIO_IN_W-1:0]  gpio_in_i,
	output logic [`SOC_GPIO_OUT_W-1:0] led_o,
	output logic                       bus_errors_en_o,
	output logic                       irq_o
);
	logic [`SOC_GPIO_IN_W-1:0]  gpio_in_q;
	logic [`SOC_GPIO_OUT_W-1:0] led_q;
	logic [1:0]                 control;
	soc_pkg::wb_data_t          timer_cmp;
	soc_pkg::wb_data_t          timer_cnt;
	logic                       irq_stat;
	logic                       sel;
	logic                       wr;
	logic                       wrap;
	soc_pkg::sysctl_reg_e       idx;

	// Decode peripheral number and register index
	assign sel  = csr.csr_a[14:10] == soc_pkg::csr_periph_t'(`SOC_SYSCTL_CSR);
	assign idx  = soc_pkg::sysctl_reg_e'(csr.csr_a[9:0]);
	assign wr   = sel & csr.csr_we;
	// Control bit 1 runs the timer
	assign wrap = control[1] & (timer_cnt == timer_cmp);

	assign led_o           = led_q;
	assign bus_errors_en_o = control[0];
	assign irq_o           = irq_stat;

	// Input sampling
	always_ff @(posedge sys_clk)
		gpio_in_q <= gpio_in_i;

	//--------------------
	// Register writes
	//--------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			led_q     <= '0;
			control   <= '0;
			timer_cmp <= '0;
			timer_cnt <= '0;
			irq_stat  <= 1'b0;
		end else begin
			// Timer, wraps to zero at the compare value
			if (wrap)
				timer_cnt <= '0;
			else if (control[1])
				timer_cnt <= timer_cnt + 1'b1;

			// Write 1 clears, a wrap in the same cycle wins
			if (wrap)
				irq_stat <= 1'b1;
			else if (wr && idx == soc_pkg::IRQ_STAT && csr.csr_dw[0])
				irq_stat <= 1'b0;

			if (wr) begin
				case (idx)
					soc_pkg::GPIO_OUT:  led_q     <= csr.csr_dw[`SOC_GPIO_OUT_W-1:0];
					soc_pkg::CONTROL:   control   <= csr.csr_dw[1:0];
					soc_pkg::TIMER_CMP: timer_cmp <= csr.csr_dw;
					soc_pkg::TIMER_CNT: timer_cnt <= csr.csr_dw;
					default: ;
				endcase
			end
		end
	end

	//--------------------
	// Registered read mux
	//--------------------
	always_ff @(posedge sys_clk) begin
		if (!sel) begin
			// Another peripheral owns this address
			csr.csr_dr <= '0;
		end else begin
			case (idx)
				soc_pkg::GPIO_IN:   csr.csr_dr <= soc_pkg::wb_data_t'(gpio_in_q);
				soc_pkg::GPIO_OUT:  csr.csr_dr <= soc_pkg::wb_data_t'(led_q);
				soc_pkg::CONTROL:   csr.csr_dr <= soc_pkg::wb_data_t'(control);
				soc_pkg::TIMER_CMP: csr.csr_dr <= timer_cmp;
				soc_pkg::TIMER_CNT: csr.csr_dr <= timer_cnt;
				soc_pkg::IRQ_STAT:  csr.csr_dr <= soc_pkg::wb_data_t'(irq_stat);
				default:            csr.csr_dr <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/bus_result.sv
//--------------------
// Bus response
// Picks ack or err and the read data for the master
//--------------------
`default_nettype none

module bus_result (
	input  logic              sys_clk,
	input  logic              sys_rst,
	bus_req_if.result         req,
	input  logic              done,
	input  soc_pkg::wb_data_t rd_data,
	input  logic              bus_errors_en,
	output soc_pkg::wb_data_t wb_dat_o,
	output logic              wb_ack_o,
	output logic              wb_err_o
);
	logic locked_err;
	logic csr_read;

	// Catch NULL pointers and similar stray accesses
	assign locked_err = bus_errors_en & (req.req_region == soc_pkg::REGION_LOCKED);
	assign csr_read   = ~req.req_we & (req.req_region == soc_pkg::REGION_CSR);

	// One-cycle response pulse after done
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wb_ack_o <= 1'b0;
			wb_err_o <= 1'b0;
		end else begin
			wb_ack_o <= done & ~locked_err;
			wb_err_o <= done & locked_err;
		end
	end

	// Zero data unless a CSR read
	always_ff @(posedge sys_clk) begin
		if (done)
			wb_dat_o <= csr_read ? rd_data : '0;
	end

endmodule

`default_nettype wire

//--- verilog/mini_soc.sv
//--------------------
// Reduced system bus core
// Reset generation, address decode, CSR bridge
// and the system controller behind one Wishbone port
//--------------------
`default_nettype none
`include "soc_macros.svh"

module mini_soc (
	input  logic                       sys_clk,
	input  logic                       trigger_reset,
	input  soc_pkg::wb_addr_t          wb_adr_i,
	input  soc_pkg::wb_data_t          wb_dat_i,
	input  logic                       wb_we_i,
	input  logic                       wb_cyc_i,
	input  logic                       wb_stb_i,
	input  logic [`SOC_GPIO_IN_W-1:0]  gpio_in_i,
	output soc_pkg::wb_data_t          wb_dat_o,
	output logic                       wb_ack_o,
	output logic                       wb_err_o,
	output logic [`SOC_GPIO_OUT_W-1:0] led_o,
	output logic                       irq_o,
	output logic                       sys_rst_o,
	output logic                       flash_rst_n_o
);
	logic              done;
	soc_pkg::wb_data_t rd_data;
	logic              bus_errors_en;

	bus_req_if req_bus ();
	csr_bus_if csr_bus ();

	//--------------------
	// Reset
	//--------------------
	reset_gen i_reset_gen (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.sys_rst_o     (sys_rst_o),
		.flash_rst_n_o (flash_rst_n_o)
	);

	//--------------------
	// Bus path
	//--------------------
	// Decoder frees up on either response
	bus_decode i_bus_decode (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst_o),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_we_i  (wb_we_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.resp     (wb_ack_o | wb_err_o),
		.req      (req_bus.decoder)
	);

	csr_bridge i_csr_bridge (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst_o),
		.req     (req_bus.bridge),
		.csr     (csr_bus.master),
		.done    (done),
		.rd_data (rd_data)
	);

	// Only CSR peripheral left
	sysctl_regs i_sysctl_regs (
		.sys_clk         (sys_clk),
		.sys_rst         (sys_rst_o),
		.csr             (csr_bus.slave),
		.gpio_in_i       (gpio_in_i),
		.led_o           (led_o),
		.bus_errors_en_o (bus_errors_en),
		.irq_o           (irq_o)
	);

	bus_result i_bus_result (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst_o),
		.req           (req_bus.result),
		.done          (done),
		.rd_data       (rd_data),
		.bus_errors_en (bus_errors_en),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.wb_err_o      (wb_err_o)
	);

endmodule

`default_nettype wire

//--- tb/mini_soc_asserts.sv
//--------------------
// Wishbone response checks
// Bound to the bus core top level
//--------------------
`default_nettype none

module mini_soc_asserts (
	input logic sys_clk,
	input logic trigger_reset,
	input logic sys_rst_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_i,
	input logic wb_err_i
);
	// Count of failed checks
	int fail_cnt = 0;

	// One response kind per access
	ack_err_excl: assert property (@(posedge sys_clk) disable iff (trigger_reset || sys_rst_i)
		!(wb_ack_i && wb_err_i))
		else begin $error("ack and err high together"); fail_cnt++; end

	// Responses last one cycle
	ack_pulse: assert property (@(posedge sys_clk) disable iff (trigger_reset || sys_rst_i)
		wb_ack_i |=> !wb_ack_i)
		else begin $error("ack held longer than one cycle"); fail_cnt++; end
	err_pulse: assert property (@(posedge sys_clk) disable iff (trigger_reset || sys_rst_i)
		wb_err_i |=> !wb_err_i)
		else begin $error("err held longer than one cycle"); fail_cnt++; end

	// No response outside a bus cycle
	resp_in_cycle: assert property (@(posedge sys_clk) disable iff (trigger_reset || sys_rst_i)
		(wb_ack_i || wb_err_i) |-> (wb_cyc_i && wb_stb_i))
		else begin $error("response without cyc and stb"); fail_cnt++; end

	// Quiet bus while the system reset is stretched
	quiet_in_reset: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		sys_rst_i |-> !(wb_ack_i || wb_err_i))
		else begin $error("response during system reset"); fail_cnt++; end

endmodule

bind mini_soc mini_soc_asserts i_asserts (
	.sys_clk       (sys_clk),
	.trigger_reset (trigger_reset),
	.sys_rst_i     (sys_rst_o),
	.wb_cyc_i      (wb_cyc_i),
	.wb_stb_i      (wb_stb_i),
	.wb_ack_i      (wb_ack_o),
	.wb_err_i      (wb_err_o)
);

`default_nettype wire

//--- tb/mini_soc_tb.sv
//--------------------
// Testbench for the reduced system bus core
// Reset sequence, GPIO, register traffic, locked range, timer irq
//--------------------
`default_nettype none
`include "soc_macros.svh"

module mini_soc_tb;
	localparam int PERIOD    = 4;
	localparam int N_RAND    = 40;
	// Upper estimate of bus accesses over all tests
	localparam int N_ACC     = 80;
	localparam int CMP_MAX   = 47;
	localparam int WD_CYCLES = N_ACC * (`SOC_ACK_BOUND + 3) + CMP_MAX + 12 + 3 + 200;
	localparam int RESP_ACK  = 0;
	localparam int RESP_ERR  = 1;
	localparam int RESP_NONE = 2;

	logic                       sys_clk;
	logic                       trigger_reset;
	logic [31:0]                wb_adr_i;
	logic [31:0]                wb_dat_i;
	logic                       wb_we_i;
	logic                       wb_cyc_i;
	logic                       wb_stb_i;
	logic [`SOC_GPIO_IN_W-1:0]  gpio_in_i;
	logic [31:0]                wb_dat_o;
	logic                       wb_ack_o;
	logic                       wb_err_o;
	logic [`SOC_GPIO_OUT_W-1:0] led_o;
	logic                       irq_o;
	logic                       sys_rst_o;
	logic                       flash_rst_n_o;

	// Reference register bank
	logic [`SOC_GPIO_OUT_W-1:0] m_led;
	logic [1:0]                 m_ctrl;
	logic [31:0]                m_cmp;
	logic                       m_irq;

	// Responses waiting for comparison
	string       tag_q[$];
	int          exp_kind_q[$];
	int          act_kind_q[$];
	logic [31:0] exp_dat_q[$];
	logic [31:0] act_dat_q[$];

	int seed     = 92;
	int n_tests  = 0;
	int n_checks = 0;
	int n_errors = 0;

	mini_soc i_dut (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.wb_adr_i      (wb_adr_i),
		.wb_dat_i      (wb_dat_i),
		.wb_we_i       (wb_we_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.gpio_in_i     (gpio_in_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.wb_err_o      (wb_err_o),
		.led_o         (led_o),
		.irq_o         (irq_o),
		.sys_rst_o     (sys_rst_o),
		.flash_rst_n_o (flash_rst_n_o)
	);

	initial sys_clk = 1'b0;
	always #(PERIOD / 2) sys_clk = ~sys_clk;

	//--------------------
	// Reference model
	//--------------------
	function automatic soc_pkg::region_e region_of(input logic [31:0] adr);
		if ((adr & 32'h6000_0000) == 32'h6000_0000)
			return soc_pkg::REGION_CSR;
		// Bits 30 down to the locked MSB all clear
		if ((adr[30:0] >> `SOC_LOCKED_MSB) == 0)
			return soc_pkg::REGION_LOCKED;
		return soc_pkg::REGION_OTHER;
	endfunction

	function automatic logic [31:0] sysctl_adr(input int idx, input logic shadow);
		logic [31:0] adr;
		adr = 32'h6000_0000 | (32'(`SOC_SYSCTL_CSR) << 12) | (32'(idx) << 2);
		if (shadow)
			adr[31] = 1'b1;
		return adr;
	endfunction

	// Expected CSR read value for a mapped address
	function automatic logic [31:0] ref_read(input logic [31:0] adr);
		if (adr[16:12] != `SOC_SYSCTL_CSR)
			return '0;
		case (adr[11:2])
			soc_pkg::GPIO_IN:   return 32'(gpio_in_i);
			soc_pkg::GPIO_OUT:  return 32'(m_led);
			soc_pkg::CONTROL:   return 32'(m_ctrl);
			soc_pkg::TIMER_CMP: return m_cmp;
			soc_pkg::IRQ_STAT:  return 32'(m_irq);
			// Counter not modelled, never read
			default:            return '0;
		endcase
	endfunction

	function automatic void model_write(input logic [31:0] adr, input logic [31:0] wdat);
		if (region_of(adr) != soc_pkg::REGION_CSR || adr[16:12] != `SOC_SYSCTL_CSR)
			return;
		case (adr[11:2])
			soc_pkg::GPIO_OUT:  m_led = wdat[`SOC_GPIO_OUT_W-1:0];
			soc_pkg::CONTROL:   m_ctrl = wdat[1:0];
			soc_pkg::TIMER_CMP: m_cmp = wdat;
			soc_pkg::IRQ_STAT:  if (wdat[0]) m_irq = 1'b0;
			default: ;
		endcase
	endfunction

	//--------------------
	// Bus master
	//--------------------
	task automatic bus_access(input logic [31:0] adr, input logic we, input logic [31:0] wdat,
			output int kind, output logic [31:0] rdat);
		int n;
		kind = RESP_NONE;
		rdat = '0;
		n    = 0;
		@(negedge sys_clk);
		wb_adr_i = adr;
		wb_dat_i = wdat;
		wb_we_i  = we;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		while (kind == RESP_NONE && n < `SOC_ACK_BOUND) begin
			@(negedge sys_clk);
			n++;
			if (wb_ack_o) begin
				kind = RESP_ACK;
				rdat = wb_dat_o;
			end else if (wb_err_o) begin
				kind = RESP_ERR;
			end
		end
		// Strobe stays up through the edge that takes the response
		@(negedge sys_clk);
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic expect_access(input string tag, input logic [31:0] adr, input logic we,
			input logic [31:0] wdat);
		int          kind;
		int          ekind;
		logic [31:0] rdat;
		logic [31:0] edat;
		ekind = (region_of(adr) == soc_pkg::REGION_LOCKED && m_ctrl[0]) ? RESP_ERR : RESP_ACK;
		edat  = (!we && region_of(adr) == soc_pkg::REGION_CSR) ? ref_read(adr) : '0;
		bus_access(adr, we, wdat, kind, rdat);
		if (we)
			model_write(adr, wdat);
		tag_q.push_back(tag);
		exp_kind_q.push_back(ekind);
		exp_dat_q.push_back(edat);
		act_dat_q.push_back(rdat);
		act_kind_q.push_back(kind);
	endtask

	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		assert (got === exp)
		else begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
			n_errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		wait (act_kind_q.size() == 0);
		@(negedge sys_clk);
		n_tests++;
		if (n_errors == errs_at_start)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, n_errors - errs_at_start);
	endtask

	//--------------------
	// Response comparison
	//--------------------
	initial begin : compare_responses
		string       tag;
		int          ek;
		int          ak;
		logic [31:0] ed;
		logic [31:0] ad;
		forever begin
			wait (act_kind_q.size() != 0);
			tag = tag_q.pop_front();
			ek  = exp_kind_q.pop_front();
			ak  = act_kind_q.pop_front();
			ed  = exp_dat_q.pop_front();
			ad  = act_dat_q.pop_front();
			n_checks++;
			assert (ak != RESP_NONE)
			else begin
				$display("%s: no ack or err came back within %0d cycles", tag, `SOC_ACK_BOUND);
				n_errors++;
			end
			if (ak != RESP_NONE) begin
				assert (ak == ek)
				else begin
					$display("[FAIL] %0t %s: response %0d, expected %0d", $time, tag, ak, ek);
					n_errors++;
				end
				assert (ad === ed)
				else begin
					$display("[FAIL] %0t %s: data %h, expected %h", $time, tag, ad, ed);
					n_errors++;
				end
			end
		end
	end

	initial begin : watchdog
		#(WD_CYCLES * PERIOD);
		$display("Watchdog expired after %0d cycles, tests did not complete", WD_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	//--------------------
	// Test sequence
	//--------------------
	initial begin : run_tests
		int          e0;
		int          k;
		int          idx;
		int          cmp;
		logic        seen;
		logic [31:0] rnd;
		logic [31:0] wdat;
		trigger_reset = 1'b1;
		wb_adr_i      = '0;
		wb_dat_i      = '0;
		wb_we_i       = 1'b0;
		wb_cyc_i      = 1'b0;
		wb_stb_i      = 1'b0;
		gpio_in_i     = '0;
		m_led         = '0;
		m_ctrl        = '0;
		m_cmp         = '0;
		m_irq         = 1'b0;

		// Reset release, edge by edge
		e0 = n_errors;
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		trigger_reset = 1'b0;
		for (k = 1; k <= `SOC_RST_HOLD + 2; k++) begin
			@(negedge sys_clk);
			check_val("flash_rst_n_o", flash_rst_n_o, k >= `SOC_FLASH_RST);
			check_val("sys_rst_o", sys_rst_o, k < `SOC_RST_HOLD);
			if (k < `SOC_RST_HOLD)
				check_val("outputs in reset", {wb_ack_o, wb_err_o, irq_o, led_o}, '0);
		end
		finish_test("reset", e0);

		// GPIO out and in
		e0 = n_errors;
		rnd = $random(seed);
		gpio_in_i = rnd[`SOC_GPIO_IN_W-1:0];
		wdat = $random(seed);
		expect_access("gpio_out wr", sysctl_adr(soc_pkg::GPIO_OUT, 1'b0), 1'b1, wdat);
		check_val("led_o", led_o, m_led);
		expect_access("gpio_out rd", sysctl_adr(soc_pkg::GPIO_OUT, 1'b0), 1'b0, '0);
		expect_access("gpio_in rd", sysctl_adr(soc_pkg::GPIO_IN, 1'b1), 1'b0, '0);
		finish_test("gpio", e0);

		// Seeded traffic over base and shadow addresses
		e0 = n_errors;
		for (k = 0; k < N_RAND; k++) begin
			rnd = $random(seed);
			case (rnd[7:0] % 3)
				0:       idx = soc_pkg::CONTROL;
				1:       idx = soc_pkg::TIMER_CMP;
				default: idx = soc_pkg::GPIO_OUT;
			endcase
			wdat = $random(seed);
			// Timer stays stopped
			if (idx == soc_pkg::CONTROL)
				wdat[1] = 1'b0;
			expect_access($sformatf("random %0d", k), sysctl_adr(idx, rnd[8]), rnd[9], wdat);
		end
		expect_access("other periph rd", 32'h6000_2008, 1'b0, '0);
		expect_access("other periph shadow", 32'hE000_3004, 1'b0, '0);
		finish_test("registers", e0);

		// Locked range with and without bus errors
		e0 = n_errors;
		expect_access("ctrl clear", sysctl_adr(soc_pkg::CONTROL, 1'b0), 1'b1, 32'h0);
		expect_access("locked rd", 32'h0000_0100, 1'b0, '0);
		expect_access("locked wr", 32'h0003_FFFC, 1'b1, $random(seed));
		expect_access("ctrl err on", sysctl_adr(soc_pkg::CONTROL, 1'b1), 1'b1, 32'h1);
		expect_access("locked rd err", 32'h0000_0100, 1'b0, '0);
		expect_access("locked wr shadow", 32'h8000_0040, 1'b1, $random(seed));
		expect_access("unmapped rd", 32'h1000_0000, 1'b0, '0);
		// CSR-like low bits outside the CSR region
		expect_access("unmapped wr", 32'h4000_1004, 1'b1, $random(seed));
		expect_access("unmapped wr", 32'h2000_100C, 1'b1, $random(seed));
		expect_access("gpio_out kept", sysctl_adr(soc_pkg::GPIO_OUT, 1'b0), 1'b0, '0);
		expect_access("cmp kept", sysctl_adr(soc_pkg::TIMER_CMP, 1'b0), 1'b0, '0);
		expect_access("ctrl kept", sysctl_adr(soc_pkg::CONTROL, 1'b0), 1'b0, '0);
		expect_access("ctrl clear", sysctl_adr(soc_pkg::CONTROL, 1'b0), 1'b1, 32'h0);
		finish_test("locked", e0);

		// Timer wrap and interrupt clear
		e0 = n_errors;
		rnd = $random(seed);
		cmp = 32 + rnd[3:0];
		expect_access("timer cmp", sysctl_adr(soc_pkg::TIMER_CMP, 1'b0), 1'b1, cmp);
		expect_access("timer on", sysctl_adr(soc_pkg::CONTROL, 1'b0), 1'b1, 32'h2);
		seen = 1'b0;
		for (k = 0; k < cmp + 12 && !seen; k++) begin
			@(negedge sys_clk);
			seen = irq_o;
		end
		n_checks++;
		assert (seen)
		else begin
			$display("Timer interrupt did not arrive within %0d cycles", cmp + 12);
			n_errors++;
		end
		// First wrap has happened by now
		m_irq = 1'b1;
		expect_access("irq stat set", sysctl_adr(soc_pkg::IRQ_STAT, 1'b0), 1'b0, '0);
		expect_access("irq clear", sysctl_adr(soc_pkg::IRQ_STAT, 1'b1), 1'b1, 32'h1);
		check_val("irq_o after clear", irq_o, 1'b0);
		expect_access("irq stat clr", sysctl_adr(soc_pkg::IRQ_STAT, 1'b0), 1'b0, '0);
		expect_access("timer off", sysctl_adr(soc_pkg::CONTROL, 1'b0), 1'b1, 32'h0);
		finish_test("timer", e0);

		n_errors += i_dut.i_asserts.fail_cnt;
		$display("Tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/soc_ifs.sv
verilog/reset_gen.sv
verilog/bus_decode.sv
verilog/csr_bridge.sv
verilog/sysctl_regs.sv
verilog/bus_result.sv
verilog/mini_soc.sv
tb/mini_soc_asserts.sv
tb/mini_soc_tb.sv

//--- Bender.yml
package:
  name: mini_soc

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/soc_pkg.sv
      - verilog/soc_ifs.sv
      - verilog/reset_gen.sv
      - verilog/bus_decode.sv
      - verilog/csr_bridge.sv
      - verilog/sysctl_regs.sv
      - verilog/bus_result.sv
      - verilog/mini_soc.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/mini_soc_asserts.sv
      - tb/mini_soc_tb.sv
